// File: list.f
src/hssl_pkt_pkg.sv
src/hssl_cfg_pkg.sv
src/route_cfg_if.sv
src/pkt_assembler.sv
src/pkt_router.sv
src/rr_arbiter.sv
src/pkt_receiver.sv
src/hssl_reg_bank.sv
src/hssl_event_top.sv
verification/tb_clock_gen.sv
verification/hssl_event_assert.sv
verification/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top -f list.f -o sim_tb_top

./obj_dir/sim_tb_top 2>&1 | tee sim.log

if grep -q "TB PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: src/hssl_cfg_pkg.sv
// configuration definitions
//   register address map for config packets
//   route and counter index types
//   reset values of the routing table
//   default table and channel sizes

`default_nettype none

package hssl_cfg_pkg;

  typedef logic [7:0] reg_addr_t;
  typedef logic [2:0] route_t;

  // single registers
  localparam reg_addr_t addr_reply_key = 8'h00;
  localparam reg_addr_t addr_mp_key    = 8'h01;

  // table bases, entry index added to the base
  localparam reg_addr_t addr_rt_key_base   = 8'h10;
  localparam reg_addr_t addr_rt_mask_base  = 8'h20;
  localparam reg_addr_t addr_rt_route_base = 8'h30;
  localparam reg_addr_t addr_mp_fmsk_base  = 8'h40;
  localparam reg_addr_t addr_mp_fsft_base  = 8'h48;

  // diagnostic counters
  typedef enum logic [1:0] {
    ctr_periph_out = 2'd0,
    ctr_config     = 2'd1,
    ctr_dropped    = 2'd2,
    ctr_routed     = 2'd3
  } ctr_idx_e;

  // key & 0 never equals all ones, so entries start disabled
  localparam logic [31:0] rt_key_reset  = 32'hffff_ffff;
  localparam logic [31:0] rt_mask_reset = 32'h0000_0000;

  localparam int num_channels_default = 8;
  localparam int num_rregs_default    = 16;
  localparam int num_mregs_default    = 4;

endpackage

`default_nettype wire

// File: src/hssl_event_top.sv
// event-to-link top level
//   assembler, router, channel-0 merge
//   receiver and register bank
//   plain packet streams on the ports

`default_nettype none

module hssl_event_top
  import hssl_pkt_pkg::*;
  import hssl_cfg_pkg::*;
#(
  parameter int num_channels = num_channels_default,
  parameter int num_rregs    = num_rregs_default,
  parameter int num_mregs    = num_mregs_default
)
(
  input  logic                    pl_clk0_buf_int,
  input  logic                    arst_n,
  input  evt_t                    evt_data,
  input  logic                    evt_vld,
  output logic                    evt_rdy,
  output pkt_t                    tx_data [num_channels],
  output logic [num_channels-1:0] tx_vld,
  input  logic [num_channels-1:0] tx_rdy,
  input  pkt_t                    rx_data,
  input  logic                    rx_vld,
  output logic                    rx_rdy
);

  // assembler to router
  pkt_t asm_data;
  logic asm_vld;
  logic asm_rdy;

  // router channel outputs
  pkt_t                    rtr_data [num_channels];
  logic [num_channels-1:0] rtr_vld;
  logic [num_channels-1:0] rtr_rdy;

  // diagnostic replies
  pkt_t rep_data;
  logic rep_vld;
  logic rep_rdy;

  // register writes and counters
  logic        wr_en;
  reg_addr_t   wr_addr;
  logic [31:0] wr_data;
  logic        cnt_drop;
  logic        cnt_routed;
  logic        cnt_config;
  logic        cnt_periph;
  logic [31:0] ctr_value [ctr_periph_out:ctr_routed];
  logic [31:0] reply_key;

  route_cfg_if #(.num_rregs(num_rregs), .num_mregs(num_mregs)) cfg_if ();

  // ------------------------------------------------------------
  // transmit path
  // ------------------------------------------------------------
  pkt_assembler #(.num_mregs(num_mregs)) u_asm (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .arst_n          (arst_n),
    .cfg             (cfg_if),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .pkt_data        (asm_data),
    .pkt_vld         (asm_vld),
    .pkt_rdy         (asm_rdy)
  );

  pkt_router #(.num_channels(num_channels), .num_rregs(num_rregs)) u_rtr (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .arst_n          (arst_n),
    .cfg             (cfg_if),
    .in_data         (asm_data),
    .in_vld          (asm_vld),
    .in_rdy          (asm_rdy),
    .out_data        (rtr_data),
    .out_vld         (rtr_vld),
    .out_rdy         (rtr_rdy),
    .cnt_drop        (cnt_drop),
    .cnt_routed      (cnt_routed)
  );

  // channel 0 shared with the replies
  rr_arbiter u_arb (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .arst_n          (arst_n),
    .in0_data        (rtr_data[0]),
    .in0_vld         (rtr_vld[0]),
    .in0_rdy         (rtr_rdy[0]),
    .in1_data        (rep_data),
    .in1_vld         (rep_vld),
    .in1_rdy         (rep_rdy),
    .out_data        (tx_data[0]),
    .out_vld         (tx_vld[0]),
    .out_rdy         (tx_rdy[0])
  );

  // remaining channels straight out
  for (genvar c = 1; c < num_channels; c++)
  begin : g_chan
    assign tx_data[c] = rtr_data[c];
    assign tx_vld[c]  = rtr_vld[c];
    assign rtr_rdy[c] = tx_rdy[c];
  end

  // ------------------------------------------------------------
  // receive path and registers
  // ------------------------------------------------------------
  pkt_receiver u_rx (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .arst_n          (arst_n),
    .rx_data         (rx_data),
    .rx_vld          (rx_vld),
    .rx_rdy          (rx_rdy),
    .reply_data      (rep_data),
    .reply_vld       (rep_vld),
    .reply_rdy       (rep_rdy),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .ctr_value       (ctr_value),
    .reply_key       (reply_key),
    .cnt_config      (cnt_config),
    .cnt_periph      (cnt_periph)
  );

  hssl_reg_bank #(.num_rregs(num_rregs), .num_mregs(num_mregs)) u_bank (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .arst_n          (arst_n),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .cnt_periph      (cnt_periph),
    .cnt_config      (cnt_config),
    .cnt_drop        (cnt_drop),
    .cnt_routed      (cnt_routed),
    .cfg             (cfg_if),
    .ctr_value       (ctr_value),
    .reply_key       (reply_key)
  );

endmodule

`default_nettype wire

// File: src/hssl_pkt_pkg.sv
// packet definitions shared by the event datapath
//   pkt_kind_e  packet kinds on the link
//   pkt_t       kind, routing key and payload
//   evt_t       raw event word from the sensor side

`default_nettype none

package hssl_pkt_pkg;

  // kind field of every packet
  typedef enum logic [1:0] {
    kind_data      = 2'd0,
    kind_cfg_write = 2'd1,
    kind_ctr_read  = 2'd2,
    kind_periph    = 2'd3
  } pkt_kind_e;

  // 66-bit packet, kind in the top bits
  typedef struct packed {
    pkt_kind_e   kind;
    logic [31:0] key;
    logic [31:0] payload;
  } pkt_t;

  typedef logic [31:0] evt_t;

endpackage

`default_nettype wire

// File: src/hssl_reg_bank.sv
// register bank
//   reply key, mapper and routing-table registers
//   four wrapping packet counters

`default_nettype none

module hssl_reg_bank
  import hssl_cfg_pkg::*;
#(
  parameter int num_rregs = num_rregs_default,
  parameter int num_mregs = num_mregs_default
)
(
  input  logic        pl_clk0_buf_int,
  input  logic        arst_n,
  input  logic        wr_en,
  input  reg_addr_t   wr_addr,
  input  logic [31:0] wr_data,
  input  logic        cnt_periph,
  input  logic        cnt_config,
  input  logic        cnt_drop,
  input  logic        cnt_routed,
  route_cfg_if.bank   cfg,
  output logic [31:0] ctr_value [ctr_periph_out:ctr_routed],
  output logic [31:0] reply_key
);

  logic [ctr_routed:ctr_periph_out] ctr_inc;

  // ------------------------------------------------------------
  // configuration registers
  // ------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
    begin
      reply_key  <= '0;
      cfg.mp_key <= '0;
      for (int i = 0; i < num_rregs; i++)
      begin
        cfg.rt_key[i]   <= rt_key_reset;
        cfg.rt_mask[i]  <= rt_mask_reset;
        cfg.rt_route[i] <= '0;
      end
      for (int i = 0; i < num_mregs; i++)
      begin
        cfg.mp_fmsk[i] <= '0;
        cfg.mp_fsft[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      if (wr_addr == addr_reply_key)
        reply_key <= wr_data;
      if (wr_addr == addr_mp_key)
        cfg.mp_key <= wr_data;
      // table entries at base + index
      for (int i = 0; i < num_rregs; i++)
      begin
        if (wr_addr == addr_rt_key_base + reg_addr_t'(i))
          cfg.rt_key[i] <= wr_data;
        if (wr_addr == addr_rt_mask_base + reg_addr_t'(i))
          cfg.rt_mask[i] <= wr_data;
        if (wr_addr == addr_rt_route_base + reg_addr_t'(i))
          cfg.rt_route[i] <= wr_data[2:0];
      end
      for (int i = 0; i < num_mregs; i++)
      begin
        if (wr_addr == addr_mp_fmsk_base + reg_addr_t'(i))
          cfg.mp_fmsk[i] <= wr_data;
        if (wr_addr == addr_mp_fsft_base + reg_addr_t'(i))
          cfg.mp_fsft[i] <= wr_data[4:0];
      end
    end
  end

  // ------------------------------------------------------------
  // packet counters
  // ------------------------------------------------------------
  assign ctr_inc[ctr_periph_out] = cnt_periph;
  assign ctr_inc[ctr_config]     = cnt_config;
  assign ctr_inc[ctr_dropped]    = cnt_drop;
  assign ctr_inc[ctr_routed]     = cnt_routed;

  // free-running, wrap at 2^32
  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < 4; i++)
        ctr_value[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (ctr_inc[i])
          ctr_value[i] <= ctr_value[i] + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/pkt_assembler.sv
// event to packet assembler
//   key built from masked, shifted event fields
//   one output register towards the router

`default_nettype none

module pkt_assembler
  import hssl_pkt_pkg::*;
  import hssl_cfg_pkg::*;
#(
  parameter int num_mregs = num_mregs_default
)
(
  input  logic              pl_clk0_buf_int,
  input  logic              arst_n,
  route_cfg_if.mapper       cfg,
  input  evt_t              evt_data,
  input  logic              evt_vld,
  output logic              evt_rdy,
  output pkt_t              pkt_data,
  output logic              pkt_vld,
  input  logic              pkt_rdy
);

  logic [31:0] key_c;

  // base key plus every field
  always_comb
  begin
    key_c = cfg.mp_key;
    for (int i = 0; i < num_mregs; i++)
    begin
      key_c = key_c | ((evt_data & cfg.mp_fmsk[i]) >> cfg.mp_fsft[i]);
    end
  end

  // register empty or draining
  assign evt_rdy = !pkt_vld || pkt_rdy;

  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
      pkt_vld <= 1'b0;
    else if (evt_rdy)
      pkt_vld <= evt_vld;
  end

  // data packet, payload unused
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (evt_vld && evt_rdy)
    begin
      pkt_data.kind    <= kind_data;
      pkt_data.key     <= key_c;
      pkt_data.payload <= '0;
    end
  end

endmodule

`default_nettype wire

// File: src/pkt_receiver.sv
// received packet decoder
//   config writes to the register bank
//   counter reads answered with a reply packet
//   peripheral packets counted and discarded

`default_nettype none

module pkt_receiver
  import hssl_pkt_pkg::*;
  import hssl_cfg_pkg::*;
(
  input  logic        pl_clk0_buf_int,
  input  logic        arst_n,
  input  pkt_t        rx_data,
  input  logic        rx_vld,
  output logic        rx_rdy,
  output pkt_t        reply_data,
  output logic        reply_vld,
  input  logic        reply_rdy,
  output logic        wr_en,
  output reg_addr_t   wr_addr,
  output logic [31:0] wr_data,
  input  logic [31:0] ctr_value [ctr_periph_out:ctr_routed],
  input  logic [31:0] reply_key,
  output logic        cnt_config,
  output logic        cnt_periph
);

  logic accept;
  logic is_write;
  logic is_read;
  logic is_periph;

  // hold the link while a reply is pending
  assign rx_rdy = !reply_vld || reply_rdy;
  assign accept = rx_vld && rx_rdy;

  // kind decode, kind_data falls through and is discarded
  assign is_write  = accept && (rx_data.kind == kind_cfg_write);
  assign is_read   = accept && (rx_data.kind == kind_ctr_read);
  assign is_periph = accept && (rx_data.kind == kind_periph);

  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_en      <= 1'b0;
      reply_vld  <= 1'b0;
      cnt_config <= 1'b0;
      cnt_periph <= 1'b0;
    end
    else
    begin
      wr_en      <= is_write;
      cnt_config <= is_write;
      cnt_periph <= is_periph;
      if (rx_rdy)
        reply_vld <= is_read;
    end
  end

  // write address from the key's low byte
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (is_write)
    begin
      wr_addr <= rx_data.key[7:0];
      wr_data <= rx_data.payload;
    end
    if (is_read)
    begin
      reply_data.kind    <= kind_data;
      reply_data.key     <= reply_key;
      reply_data.payload <= ctr_value[ctr_idx_e'(rx_data.key[1:0])];
    end
  end

endmodule

`default_nettype wire

// File: src/pkt_router.sv
// key/mask packet router
//   lowest matching entry picks the channel
//   unmatched packets dropped and counted
//   one output register per channel

`default_nettype none

module pkt_router
  import hssl_pkt_pkg::*;
  import hssl_cfg_pkg::*;
#(
  parameter int num_channels = num_channels_default,
  parameter int num_rregs    = num_rregs_default
)
(
  input  logic                    pl_clk0_buf_int,
  input  logic                    arst_n,
  route_cfg_if.router             cfg,
  input  pkt_t                    in_data,
  input  logic                    in_vld,
  output logic                    in_rdy,
  output pkt_t                    out_data [num_channels],
  output logic [num_channels-1:0] out_vld,
  input  logic [num_channels-1:0] out_rdy,
  output logic                    cnt_drop,
  output logic                    cnt_routed
);

  logic                    hit;
  route_t                  sel;
  logic [num_channels-1:0] free;
  logic                    accept;

  // ------------------------------------------------------------
  // table lookup
  // ------------------------------------------------------------
  // scan downwards so the lowest index is left in sel
  always_comb
  begin
    hit = 1'b0;
    sel = '0;
    for (int i = num_rregs - 1; i >= 0; i--)
    begin
      if ((in_data.key & cfg.rt_mask[i]) == cfg.rt_key[i])
      begin
        hit = 1'b1;
        sel = cfg.rt_route[i];
      end
    end
  end

  // channel register empty or draining
  assign free = ~out_vld | out_rdy;

  // drops never wait, matches wait for their channel
  assign in_rdy = !hit || free[sel];
  assign accept = in_vld && in_rdy;

  // ------------------------------------------------------------
  // channel registers
  // ------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_vld    <= '0;
      cnt_drop   <= 1'b0;
      cnt_routed <= 1'b0;
    end
    else
    begin
      for (int c = 0; c < num_channels; c++)
      begin
        if (free[c])
          out_vld[c] <= accept && hit && (sel == c);
      end
      // counter pulses
      cnt_drop   <= accept && !hit;
      cnt_routed <= accept && hit;
    end
  end

  always_ff @(posedge pl_clk0_buf_int)
  begin
    for (int c = 0; c < num_channels; c++)
    begin
      if (free[c] && accept && hit && (sel == c))
        out_data[c] <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: src/route_cfg_if.sv
// mapper and routing-table registers
// from the register bank to the datapath
// modports for the bank, the mapper and the router

`default_nettype none

interface route_cfg_if
  import hssl_cfg_pkg::*;
#(
  parameter int num_rregs = num_rregs_default,
  parameter int num_mregs = num_mregs_default
);

  // event mapper
  logic [31:0] mp_key;
  logic [31:0] mp_fmsk [num_mregs];
  logic [4:0]  mp_fsft [num_mregs];

  // routing table
  logic [31:0] rt_key   [num_rregs];
  logic [31:0] rt_mask  [num_rregs];
  route_t      rt_route [num_rregs];

  modport bank (output mp_key, mp_fmsk, mp_fsft, rt_key, rt_mask, rt_route);
  modport mapper (input mp_key, mp_fmsk, mp_fsft);
  modport router (input rt_key, rt_mask, rt_route);

endinterface

`default_nettype wire

// File: src/rr_arbiter.sv
// two-input round-robin packet merge
//   priority flips after a grant with both inputs waiting
//   one output register

`default_nettype none

module rr_arbiter
  import hssl_pkt_pkg::*;
(
  input  logic pl_clk0_buf_int,
  input  logic arst_n,
  input  pkt_t in0_data,
  input  logic in0_vld,
  output logic in0_rdy,
  input  pkt_t in1_data,
  input  logic in1_vld,
  output logic in1_rdy,
  output pkt_t out_data,
  output logic out_vld,
  input  logic out_rdy
);

  // 0 favours in0, 1 favours in1
  logic pri;
  logic free;

  assign free = !out_vld || out_rdy;

  // an input is held off only when the other one has priority and waits
  assign in0_rdy = free && !(pri && in1_vld);
  assign in1_rdy = free && !(!pri && in0_vld);

  always_ff @(posedge pl_clk0_buf_int or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_vld <= 1'b0;
      pri     <= 1'b0;
    end
    else if (free)
    begin
      out_vld <= (in0_vld && in0_rdy) || (in1_vld && in1_rdy);
      // contention, hand priority over
      if (in0_vld && in1_vld)
        pri <= !pri;
    end
  end

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (in1_vld && in1_rdy)
      out_data <= in1_data;
    else if (in0_vld && in0_rdy)
      out_data <= in0_data;
  end

endmodule

`default_nettype wire

// File: verification/hssl_event_assert.sv
// concurrent checks bound into the event top level
//   tx valids low during and right after reset
//   stalled tx packets held stable
//   reply keys never unknown

`default_nettype none

module hssl_event_assert
  import hssl_pkt_pkg::*;
#(
  parameter int num_channels = 8
)
(
  input logic                    pl_clk0_buf_int,
  input logic                    arst_n,
  input pkt_t                    tx_data [num_channels],
  input logic [num_channels-1:0] tx_vld,
  input logic [num_channels-1:0] tx_rdy,
  input pkt_t                    rep_data,
  input logic                    rep_vld
);

  // ------------------------------------------------------------
  // reset
  // ------------------------------------------------------------
  assert property (@(posedge pl_clk0_buf_int) !arst_n |-> tx_vld == '0)
    else $error("tx valid high while reset is asserted");

  assert property (@(posedge pl_clk0_buf_int) !arst_n |=> tx_vld == '0)
    else $error("tx valid high in the first cycle after reset");

  // ------------------------------------------------------------
  // stream rules
  // ------------------------------------------------------------
  // a stalled packet keeps vld and data until taken
  for (genvar c = 0; c < num_channels; c++)
  begin : g_hold
    assert property (@(posedge pl_clk0_buf_int) disable iff (!arst_n)
      tx_vld[c] && !tx_rdy[c] |=> tx_vld[c] && $stable(tx_data[c]))
      else $error("channel %0d changed a stalled packet", c);
  end

  assert property (@(posedge pl_clk0_buf_int) disable iff (!arst_n)
    rep_vld |-> !$isunknown(rep_data.key))
    else $error("reply packet with unknown key");

endmodule

// reply stream taken from inside the top level
bind hssl_event_top hssl_event_assert #(.num_channels(num_channels)) u_chk (
  .pl_clk0_buf_int (pl_clk0_buf_int),
  .arst_n          (arst_n),
  .tx_data         (tx_data),
  .tx_vld          (tx_vld),
  .tx_rdy          (tx_rdy),
  .rep_data        (rep_data),
  .rep_vld         (rep_vld)
);

`default_nettype wire

// File: verification/tb_clock_gen.sv
// testbench clock and reset source
//   free-running clock, 100 time units per period
//   active-low asynchronous reset held for 3 cycles

`default_nettype none

module tb_clock_gen
#(
  parameter int half_period  = 50,
  parameter int reset_cycles = 3
)
(
  output logic pl_clk0_buf_int,
  output logic arst_n
);

  initial
  begin
    pl_clk0_buf_int = 1'b0;
    forever
      #half_period pl_clk0_buf_int = ~pl_clk0_buf_int;
  end

  // release on a falling edge, away from the flops
  initial
  begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(negedge pl_clk0_buf_int);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_top.sv
// testbench for the event-to-link top level
//   stream drivers for events and received packets
//   reference model of mapper, routing table and counters
//   tx monitor, six tests, per-test report and summary

`default_nettype none

module tb_top
  import hssl_pkt_pkg::*;
  import hssl_cfg_pkg::*;
();

  localparam int num_channels = num_channels_default;
  localparam int wait_limit   = 200;

  // one observed or expected tx packet
  typedef struct packed {
    logic [2:0] ch;
    pkt_t       p;
  } out_t;

  logic                    pl_clk0_buf_int;
  logic                    arst_n;
  evt_t                    evt_data;
  logic                    evt_vld;
  logic                    evt_rdy;
  pkt_t                    tx_data [num_channels];
  logic [num_channels-1:0] tx_vld;
  logic [num_channels-1:0] tx_rdy;
  pkt_t                    rx_data;
  logic                    rx_vld;
  logic                    rx_rdy;

  // model of the register bank
  logic [31:0] m_reply;
  logic [31:0] m_mpkey;
  logic [31:0] m_fmsk  [num_mregs_default];
  logic [4:0]  m_fsft  [num_mregs_default];
  logic [31:0] m_rkey  [num_rregs_default];
  logic [31:0] m_rmask [num_rregs_default];
  logic [2:0]  m_route [num_rregs_default];
  int          drop_cnt   = 0;
  int          routed_cnt = 0;
  int          cfg_cnt    = 0;
  int          periph_cnt = 0;

  out_t        exp_q [$];
  out_t        got_q [$];
  logic [31:0] rng;
  string       cur_test;
  int          test_errs = 0;
  int          err_total = 0;
  int          n_pass    = 0;
  int          n_fail    = 0;

  tb_clock_gen u_clk (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .arst_n          (arst_n)
  );

  hssl_event_top #(
    .num_channels (num_channels),
    .num_rregs    (num_rregs_default),
    .num_mregs    (num_mregs_default)
  ) dut0 (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .arst_n          (arst_n),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .tx_data         (tx_data),
    .tx_vld          (tx_vld),
    .tx_rdy          (tx_rdy),
    .rx_data         (rx_data),
    .rx_vld          (rx_vld),
    .rx_rdy          (rx_rdy)
  );

  // ------------------------------------------------------------
  // tx monitor
  // ------------------------------------------------------------
  // pre-edge values, so each transfer is seen once
  always @(posedge pl_clk0_buf_int)
  begin
    out_t o;
    if (arst_n)
    begin
      for (int c = 0; c < num_channels; c++)
      begin
        if (tx_vld[c] && tx_rdy[c])
        begin
          o.ch = 3'(c);
          o.p  = tx_data[c];
          got_q.push_back(o);
        end
      end
    end
  end

  // hard stop if a test never returns
  initial
  begin
    repeat (20000) @(posedge pl_clk0_buf_int);
    $display("Error: simulation did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report(input string msg);
    $display("Error in %s: %s", cur_test, msg);
    test_errs++;
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp)
    else
    begin
      $display("Mismatch in %s: %s expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic settle();
    repeat (4) @(negedge pl_clk0_buf_int);
  endtask

  // key = base key OR each masked field shifted right
  function automatic logic [31:0] map_key(input evt_t e);
    logic [31:0] k;
    k = m_mpkey;
    for (int i = 0; i < num_mregs_default; i++)
      k = k | ((e & m_fmsk[i]) >> m_fsft[i]);
    return k;
  endfunction

  // lowest matching table entry wins, no match is a drop
  task automatic expect_evt(input evt_t e);
    out_t o;
    logic hit;
    o.p.kind    = kind_data;
    o.p.key     = map_key(e);
    o.p.payload = '0;
    o.ch        = '0;
    hit         = 1'b0;
    for (int i = 0; i < num_rregs_default; i++)
    begin
      if (!hit && ((o.p.key & m_rmask[i]) == m_rkey[i]))
      begin
        hit  = 1'b1;
        o.ch = m_route[i];
      end
    end
    if (hit)
    begin
      exp_q.push_back(o);
      routed_cnt++;
    end
    else
      drop_cnt++;
  endtask

  // entered on a falling edge, leaves on one with vld low
  task automatic send_evt(input evt_t e);
    int t;
    evt_data = e;
    evt_vld  = 1'b1;
    t = 0;
    #1;
    while (!evt_rdy && t < wait_limit)
    begin
      @(negedge pl_clk0_buf_int);
      #1;
      t++;
    end
    if (!evt_rdy)
      report("event input never became ready");
    @(negedge pl_clk0_buf_int);
    evt_vld = 1'b0;
  endtask

  task automatic send_rx(input pkt_t p);
    int t;
    rx_data = p;
    rx_vld  = 1'b1;
    t = 0;
    #1;
    while (!rx_rdy && t < wait_limit)
    begin
      @(negedge pl_clk0_buf_int);
      #1;
      t++;
    end
    if (!rx_rdy)
      report("receive input never became ready");
    @(negedge pl_clk0_buf_int);
    rx_vld = 1'b0;
  endtask

  task automatic send_random(input int n);
    for (int i = 0; i < n; i++)
    begin
      rng = xorshift(rng);
      expect_evt(rng);
      send_evt(rng);
    end
  endtask

  task automatic cfg_write(input reg_addr_t addr, input logic [31:0] data);
    pkt_t p;
    p.kind    = kind_cfg_write;
    p.key     = {24'd0, addr};
    p.payload = data;
    send_rx(p);
    cfg_cnt++;
  endtask

  task automatic set_route(input int i, input logic [31:0] key, input logic [31:0] mask,
                           input logic [2:0] ch);
    cfg_write(addr_rt_key_base + reg_addr_t'(i), key);
    cfg_write(addr_rt_mask_base + reg_addr_t'(i), mask);
    cfg_write(addr_rt_route_base + reg_addr_t'(i), {29'd0, ch});
    m_rkey[i]  = key;
    m_rmask[i] = mask;
    m_route[i] = ch;
  endtask

  task automatic set_field(input int i, input logic [31:0] msk, input logic [4:0] sft);
    cfg_write(addr_mp_fmsk_base + reg_addr_t'(i), msk);
    cfg_write(addr_mp_fsft_base + reg_addr_t'(i), {27'd0, sft});
    m_fmsk[i] = msk;
    m_fsft[i] = sft;
  endtask

  // first reply on channel 0, -1 if none yet
  function automatic int find_reply();
    for (int j = 0; j < got_q.size(); j++)
    begin
      if (got_q[j].ch == 3'd0 && got_q[j].p.key == m_reply)
        return j;
    end
    return -1;
  endfunction

  task automatic take_reply(input logic [31:0] exp, input string what);
    int t;
    int j;
    t = 0;
    while (find_reply() < 0 && t < wait_limit)
    begin
      @(negedge pl_clk0_buf_int);
      t++;
    end
    j = find_reply();
    if (j < 0)
      report($sformatf("no reply arrived for the %s read", what));
    else
    begin
      check_val(what, exp, got_q[j].p.payload);
      check_val({what, " reply kind"}, 32'(kind_data), 32'(got_q[j].p.kind));
      got_q.delete(j);
    end
  endtask

  task automatic read_ctr(input ctr_idx_e idx, input logic [31:0] exp, input string what);
    pkt_t p;
    settle();
    p.kind    = kind_ctr_read;
    p.key     = {30'd0, idx};
    p.payload = '0;
    send_rx(p);
    take_reply(exp, what);
  endtask

  task automatic wait_out(input int extra);
    int t;
    t = 0;
    while (got_q.size() < exp_q.size() + extra && t < wait_limit)
    begin
      @(negedge pl_clk0_buf_int);
      t++;
    end
    if (got_q.size() < exp_q.size() + extra)
      report("timed out waiting for output packets");
    settle();
  endtask

  // order is checked per channel
  task automatic check_out();
    out_t e;
    int   j;
    while (exp_q.size() > 0)
    begin
      e = exp_q.pop_front();
      j = -1;
      for (int k = 0; k < got_q.size() && j < 0; k++)
      begin
        if (got_q[k].ch == e.ch)
          j = k;
      end
      if (j < 0)
        report($sformatf("packet with key %h missing on channel %0d", e.p.key, e.ch));
      else
      begin
        check_val($sformatf("channel %0d key", e.ch), e.p.key, got_q[j].p.key);
        check_val($sformatf("channel %0d payload", e.ch), e.p.payload, got_q[j].p.payload);
        check_val($sformatf("channel %0d kind", e.ch), 32'(e.p.kind), 32'(got_q[j].p.kind));
        got_q.delete(j);
      end
    end
    assert (got_q.size() == 0)
    else
      report($sformatf("%0d unexpected output packets", got_q.size()));
    got_q.delete();
  endtask

  task automatic end_test();
    if (test_errs == 0)
    begin
      $display("test %s: pass", cur_test);
      n_pass++;
    end
    else
    begin
      $display("test %s: %0d errors", cur_test, test_errs);
      n_fail++;
    end
    err_total += test_errs;
    test_errs = 0;
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  initial
  begin
    int   t;
    evt_t e;
    pkt_t p;

    evt_data = '0;
    evt_vld  = 1'b0;
    tx_rdy   = '1;
    rx_data  = '0;
    rx_vld   = 1'b0;
    rng      = 32'd68300;

    // model at its reset values
    m_reply = '0;
    m_mpkey = '0;
    for (int i = 0; i < num_mregs_default; i++)
    begin
      m_fmsk[i] = '0;
      m_fsft[i] = '0;
    end
    for (int i = 0; i < num_rregs_default; i++)
    begin
      m_rkey[i]  = rt_key_reset;
      m_rmask[i] = rt_mask_reset;
      m_route[i] = '0;
    end

    cur_test = "reset_state";
    t = 0;
    while (arst_n !== 1'b1 && t < wait_limit)
    begin
      @(negedge pl_clk0_buf_int);
      #1;
      t++;
    end
    if (arst_n !== 1'b1)
      report("reset was never released");
    @(negedge pl_clk0_buf_int);

    // 1: nothing routes before configuration
    assert (tx_vld == '0)
    else
      report("tx valid set after reset");
    assert (evt_rdy && rx_rdy)
    else
      report("event or receive input not ready after reset");
    send_random(5);
    wait_out(0);
    check_out();
    read_ctr(ctr_dropped, drop_cnt, "dropped count");
    end_test();

    // 2: one mapper field, entry 0 to channel 3
    cur_test = "configure";
    cfg_write(addr_reply_key, 32'ha5a5_0000);
    m_reply = 32'ha5a5_0000;
    set_field(0, 32'h0000_ff00, 5'd8);
    cfg_write(addr_mp_key, 32'h1234_0000);
    m_mpkey = 32'h1234_0000;
    set_route(0, 32'h1234_0000, 32'hffff_0000, 3'd3);
    settle();
    send_random(6);
    wait_out(0);
    check_out();
    end_test();

    // 3: entries 1 and 2 overlap on 0x567, entry 1 wins
    cur_test = "priority_drop";
    set_field(0, 32'hff00_0000, 5'd0);
    cfg_write(addr_mp_key, 32'h0070_0000);
    m_mpkey = 32'h0070_0000;
    set_route(1, 32'h5600_0000, 32'hff00_0000, 3'd5);
    set_route(2, 32'h5670_0000, 32'hfff0_0000, 3'd6);
    settle();
    for (int i = 0; i < 10; i++)
    begin
      rng = xorshift(rng);
      e = (i % 2 == 0) ? {8'h56, rng[23:0]} : rng;
      expect_evt(e);
      send_evt(e);
    end
    wait_out(0);
    check_out();
    read_ctr(ctr_dropped, drop_cnt, "dropped count");
    end_test();

    // 4: routed traffic and replies share channel 0
    cur_test = "merge_ch0";
    set_route(0, 32'h0000_0000, 32'h0000_0000, 3'd0);
    settle();
    p.kind    = kind_ctr_read;
    p.key     = {30'd0, ctr_config};
    p.payload = '0;
    fork
      send_random(8);
      begin
        for (int i = 0; i < 4; i++)
          send_rx(p);
      end
    join
    wait_out(4);
    for (int i = 0; i < 4; i++)
      take_reply(cfg_cnt, "config count");
    check_out();
    end_test();

    // 5: channel 3 stalled, assembler and router fill up
    cur_test = "backpressure";
    set_route(0, 32'h0000_0000, 32'h0000_0000, 3'd3);
    settle();
    tx_rdy[3] = 1'b0;
    send_random(2);
    rng = xorshift(rng);
    e = rng;
    expect_evt(e);
    evt_data = e;
    evt_vld  = 1'b1;
    t = 0;
    #1;
    while (evt_rdy && t < 20)
    begin
      @(negedge pl_clk0_buf_int);
      #1;
      t++;
    end
    assert (!evt_rdy)
    else
      report("event input did not stall");
    repeat (5) @(negedge pl_clk0_buf_int);
    assert (got_q.size() == 0)
    else
      report("packet left a stalled channel");
    tx_rdy[3] = 1'b1;
    send_evt(e);
    send_random(3);
    wait_out(0);
    check_out();
    end_test();

    // 6: peripheral, config and routed counters
    cur_test = "counters";
    for (int i = 0; i < 5; i++)
    begin
      rng       = xorshift(rng);
      p.kind    = kind_periph;
      p.key     = rng;
      rng       = xorshift(rng);
      p.payload = rng;
      send_rx(p);
      periph_cnt++;
    end
    read_ctr(ctr_periph_out, periph_cnt, "peripheral count");
    read_ctr(ctr_config, cfg_cnt, "config count");
    read_ctr(ctr_routed, routed_cnt, "routed count");
    settle();
    check_out();
    end_test();

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             n_pass, n_fail, err_total);
    if (err_total == 0 && n_fail == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
